// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dcache_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a crashed or stopped run counts as a failure in the log
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	@cat $(LOG)
	@! grep -q "Simulation failed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/dcache_ctrl.sv
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_ctrl (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               cpu_cyc,
	input  logic               cpu_stb,
	input  logic               cpu_we,
	input  dcache_pkg::addr_t  cpu_adr,
	output dcache_pkg::word_t  cpu_dat_r,
	output logic               cpu_ack,
	output logic               mem_cyc,
	output logic               mem_stb,
	output logic               mem_we,
	output dcache_pkg::addr_t  mem_adr,
	output dcache_pkg::word_t  mem_dat_w,
	input  dcache_pkg::word_t  mem_dat_r,
	input  logic               mem_ack,
	output dcache_pkg::index_t index,
	output dcache_pkg::tag_t   tag,
	output logic               fill_en,
	output logic               fill_way,
	output logic               dirty_set_en,
	output logic               dirty_way,
	output logic               lru_touch_en,
	input  logic               hit,
	input  logic               hit_way,
	input  logic               victim_way,
	input  logic               victim_dirty,
	input  dcache_pkg::tag_t   victim_tag,
	output logic               way,
	output dcache_pkg::beat_t  word_sel,
	output logic               wr_en,
	output dcache_pkg::bsel_t  be,
	output dcache_pkg::word_t  wr_data,
	input  dcache_pkg::word_t  rd_data,
	input  dcache_pkg::bsel_t  be_lane,
	input  dcache_pkg::word_t  lane_data,
	input  dcache_pkg::word_t  load_data
);
	import dcache_pkg::*;

	localparam int OFF_W = $bits(offset_t);
	localparam int IDX_W = $bits(index_t);
	localparam int BEAT_W = $bits(beat_t);
	localparam int BYTE_W = OFF_W - BEAT_W; // byte within a word

	ctrl_state_t state, state_nxt;
	beat_t beat;
	logic req, lookup_hit, in_burst, last_beat;

	assign req = cpu_cyc && cpu_stb && (state == st_idle);
	assign lookup_hit = req && hit;
	assign in_burst = (state == st_write_back) || (state == st_fill);
	assign last_beat = (beat == beat_t'(`DC_BEATS - 1));

	assign index = cpu_adr[OFF_W +: IDX_W];
	assign tag = cpu_adr[$bits(addr_t)-1 -: $bits(tag_t)];

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (req) begin
					if (hit) begin
						state_nxt = st_ack;
					end else if (victim_dirty) begin
						state_nxt = st_write_back;
					end else begin
						state_nxt = st_fill;
					end
				end
			end
			st_ack: state_nxt = st_idle;
			st_write_back: if (mem_ack && last_beat) state_nxt = st_fill;
			st_fill: if (mem_ack && last_beat) state_nxt = st_idle; // request looks up again
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			beat <= '0;
		end else begin
			state <= state_nxt;
			if (!in_burst) begin
				beat <= '0;
			end else if (mem_ack) begin
				beat <= beat + 1'b1; // wraps to 0 between writeback and fill
			end
		end
	end

	// load result captured on the sampling edge
	always_ff @(posedge clk) begin
		if (lookup_hit && !cpu_we) begin
			cpu_dat_r <= load_data;
		end
	end

	assign cpu_ack = (state == st_ack);

	// one classic cycle per beat, stb held across the burst
	assign mem_cyc = in_burst;
	assign mem_stb = in_burst;
	assign mem_we = (state == st_write_back);
	assign mem_adr = {(state == st_write_back) ? victim_tag : tag, index, beat,
		{BYTE_W{1'b0}}};
	assign mem_dat_w = rd_data; // victim word selected by beat

	assign fill_en = (state == st_fill) && mem_ack && last_beat;
	assign fill_way = victim_way;
	assign dirty_set_en = lookup_hit && cpu_we;
	assign dirty_way = hit_way;
	assign lru_touch_en = lookup_hit;

	// data store shared by store hits, refill and writeback
	assign way = (state == st_idle) ? hit_way : victim_way;
	assign word_sel = (state == st_idle) ? cpu_adr[OFF_W-1 -: BEAT_W] : beat;
	assign wr_en = dirty_set_en || ((state == st_fill) && mem_ack);
	assign be = (state == st_fill) ? '1 : be_lane;
	assign wr_data = (state == st_fill) ? mem_dat_r : lane_data;

endmodule

// File: source/dcache_data_store.sv
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_data_store (
	input  logic               clk,
	input  dcache_pkg::index_t index,
	input  logic               way,
	input  dcache_pkg::beat_t  word_sel,
	input  logic               wr_en,
	input  dcache_pkg::bsel_t  be,
	input  dcache_pkg::word_t  wr_data,
	output dcache_pkg::word_t  rd_data
);
	import dcache_pkg::*;

	localparam int SLOT_W = 1 + $bits(index_t) + $bits(beat_t);

	// both ways of every line, one entry per word
	word_t mem [2*`DC_SETS*`DC_BEATS];
	logic [SLOT_W-1:0] slot;

	assign slot = {way, index, word_sel};

	// refill passes all enables, a store only its own bytes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < $bits(bsel_t); b++) begin
				if (be[b]) begin
					mem[slot][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
	end

	assign rd_data = mem[slot]; // load word or writeback beat

endmodule

// File: source/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// byte address width on both buses
`define DC_ADDR_W 32

// data word width, one memory beat
`define DC_WORD_W 64

// bytes held by one cache line
`define DC_LINE_BYTES 64

// sets per way, kept small to force conflicts
`define DC_SETS 16

// memory transfers needed to move one line
`define DC_BEATS (`DC_LINE_BYTES / 8)

`endif

// File: source/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

	typedef logic [`DC_ADDR_W-1:0] addr_t; // byte address
	typedef logic [`DC_WORD_W-1:0] word_t; // one data word

	typedef logic [$clog2(`DC_SETS)-1:0] index_t; // set index
	typedef logic [$clog2(`DC_LINE_BYTES)-1:0] offset_t; // byte within line

	// tag is whatever remains above index and offset
	typedef logic [`DC_ADDR_W-$clog2(`DC_SETS)-$clog2(`DC_LINE_BYTES)-1:0] tag_t;

	typedef logic [$clog2(`DC_BEATS)-1:0] beat_t; // word within line
	typedef logic [`DC_WORD_W/8-1:0] bsel_t; // byte enables of a word

	typedef enum logic [1:0] {
		size_byte  = 2'd0,
		size_half  = 2'd1,
		size_word  = 2'd2,
		size_dword = 2'd3
	} size_t;

	typedef enum logic [1:0] {
		st_idle       = 2'd0, // waiting for a cpu request
		st_ack        = 2'd1, // hit answered this cycle
		st_write_back = 2'd2, // dirty victim going out
		st_fill       = 2'd3  // new line coming in
	} ctrl_state_t;

endpackage

// File: source/dcache_tag_store.sv
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_tag_store (
	input  logic              clk,
	input  logic              arst_n,
	input  dcache_pkg::index_t index,
	input  dcache_pkg::tag_t  tag,
	input  logic              fill_en,
	input  logic              fill_way,
	input  logic              dirty_set_en,
	input  logic              dirty_way,
	input  logic              lru_touch_en,
	output logic              hit,
	output logic              hit_way,
	output logic              victim_way,
	output logic              victim_dirty,
	output dcache_pkg::tag_t  victim_tag
);
	import dcache_pkg::*;

	tag_t tags [2][`DC_SETS];
	logic [`DC_SETS-1:0] valid [2];
	logic [`DC_SETS-1:0] dirty [2];
	logic [`DC_SETS-1:0] lru; // points at the way to replace next
	logic [1:0] way_hit;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid[w][index] && (tags[w][index] == tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1]; // way 0 unless way 1 matched

	// victim is simply the lru way, valid or not
	assign victim_way = lru[index];
	assign victim_dirty = valid[victim_way][index] && dirty[victim_way][index];
	assign victim_tag = tags[victim_way][index];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int w = 0; w < 2; w++) begin
				valid[w] <= '0;
				dirty[w] <= '0;
				for (int s = 0; s < `DC_SETS; s++) begin
					tags[w][s] <= '0;
				end
			end
			lru <= '0; // way 0 goes first
		end else begin
			// refill done, line now clean and valid
			if (fill_en) begin
				tags[fill_way][index] <= tag;
				valid[fill_way][index] <= 1'b1;
				dirty[fill_way][index] <= 1'b0;
				lru[index] <= ~fill_way;
			end
			if (dirty_set_en) begin
				dirty[dirty_way][index] <= 1'b1; // store hit
			end
			if (lru_touch_en) begin
				lru[index] <= ~hit_way; // other way becomes lru
			end
		end
	end

endmodule

// File: source/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              cpu_cyc,
	input  logic              cpu_stb,
	input  logic              cpu_we,
	input  dcache_pkg::addr_t cpu_adr,
	input  dcache_pkg::size_t cpu_size,
	input  logic              cpu_unsigned,
	input  dcache_pkg::word_t cpu_dat_w,
	output dcache_pkg::word_t cpu_dat_r,
	output logic              cpu_ack,
	output logic              mem_cyc,
	output logic              mem_stb,
	output logic              mem_we,
	output dcache_pkg::addr_t mem_adr,
	output dcache_pkg::word_t mem_dat_w,
	input  dcache_pkg::word_t mem_dat_r,
	input  logic              mem_ack
);
	import dcache_pkg::*;

	index_t index;
	tag_t tag, victim_tag;
	logic fill_en, fill_way, dirty_set_en, dirty_way, lru_touch_en;
	logic hit, hit_way, victim_way, victim_dirty;
	logic way, wr_en;
	beat_t word_sel;
	bsel_t be, be_lane;
	word_t wr_data, rd_data, lane_data, load_data;

	dcache_ctrl u_ctrl (
		.clk, .arst_n,
		.cpu_cyc, .cpu_stb, .cpu_we, .cpu_adr, .cpu_dat_r, .cpu_ack,
		.mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_dat_r, .mem_ack,
		.index, .tag, .fill_en, .fill_way, .dirty_set_en, .dirty_way, .lru_touch_en,
		.hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.way, .word_sel, .wr_en, .be, .wr_data, .rd_data,
		.be_lane, .lane_data, .load_data
	);

	dcache_tag_store u_tags (
		.clk, .arst_n, .index, .tag, .fill_en, .fill_way, .dirty_set_en, .dirty_way,
		.lru_touch_en, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
	);

	dcache_data_store u_data (
		.clk, .index, .way, .word_sel, .wr_en, .be, .wr_data, .rd_data
	);

	dcache_word_lane u_lane (
		.offset      (cpu_adr[2:0]),
		.size        (cpu_size),
		.is_unsigned (cpu_unsigned),
		.store_data  (cpu_dat_w),
		.line_word   (rd_data),
		.be          (be_lane),
		.lane_data   (lane_data),
		.load_data   (load_data)
	);

endmodule

// File: source/dcache_word_lane.sv
`timescale 1ns/100ps

module dcache_word_lane (
	input  logic              [2:0] offset,
	input  dcache_pkg::size_t size,
	input  logic              is_unsigned,
	input  dcache_pkg::word_t store_data,
	input  dcache_pkg::word_t line_word,
	output dcache_pkg::bsel_t be,
	output dcache_pkg::word_t lane_data,
	output dcache_pkg::word_t load_data
);
	import dcache_pkg::*;

	logic [5:0] shamt; // byte offset in bits
	word_t aligned;

	assign shamt = {offset, 3'b000};
	assign lane_data = store_data << shamt; // store bytes into their lane
	assign aligned = line_word >> shamt;

	always_comb begin
		case (size)
			size_byte: be = bsel_t'(8'h01) << offset;
			size_half: be = bsel_t'(8'h03) << offset;
			size_word: be = bsel_t'(8'h0f) << offset;
			default:   be = 8'hff;
		endcase
	end

	// zero or sign fill above the addressed bytes
	always_comb begin
		case (size)
			size_byte: load_data = {{56{~is_unsigned & aligned[7]}}, aligned[7:0]};
			size_half: load_data = {{48{~is_unsigned & aligned[15]}}, aligned[15:0]};
			size_word: load_data = {{32{~is_unsigned & aligned[31]}}, aligned[31:0]};
			default:   load_data = aligned; // full word, nothing to extend
		endcase
	end

endmodule

// File: tb.f
+incdir+source
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_word_lane.sv
source/dcache_ctrl.sv
source/dcache_top.sv
test/dcache_props.sv
test/dcache_tb.sv

// File: test/dcache_props.sv
`timescale 1ns/100ps

module dcache_props (
	input logic              clk,
	input logic              arst_n,
	input logic              cpu_cyc,
	input logic              cpu_stb,
	input logic              cpu_ack,
	input logic              mem_cyc,
	input logic              mem_stb,
	input logic              mem_we,
	input logic              mem_ack,
	input dcache_pkg::addr_t mem_adr,
	input dcache_pkg::word_t mem_dat_w
);

	ack_with_request: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_ack |-> cpu_cyc && cpu_stb)
		else $error("cpu_ack raised without cpu_cyc and cpu_stb");

	ack_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_ack |=> !cpu_ack)
		else $error("cpu_ack held for more than one cycle");

	// stalled beat stays inside its cycle with direction and data unchanged
	beat_held_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
		mem_stb && !mem_ack |=> mem_cyc && mem_stb && $stable(mem_we) && $stable(mem_dat_w))
		else $error("memory beat dropped or changed while stalled");

	// stalled beat keeps its address
	adr_held_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
		mem_stb && !mem_ack |=> $stable(mem_adr))
		else $error("mem_adr changed while the beat was stalled");

endmodule

bind dcache_top dcache_props u_props (
	.clk, .arst_n, .cpu_cyc, .cpu_stb, .cpu_ack,
	.mem_cyc, .mem_stb, .mem_we, .mem_ack, .mem_adr, .mem_dat_w
);

// File: test/dcache_tb.sv
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_tb;
	import dcache_pkg::*;

	localparam int N_ACC = 2000;
	localparam int SPAN = 4 * `DC_SETS * `DC_LINE_BYTES; // four tags deep
	localparam int MAX_CYC = N_ACC * (2 + 16 * 5) + 1000;
	localparam int OFF_W = $clog2(`DC_LINE_BYTES);
	localparam int IDX_W = $clog2(`DC_SETS);

	typedef logic [$clog2(SPAN)-1:0] span_t;

	logic clk, arst_n;
	logic cpu_cyc, cpu_stb, cpu_we, cpu_unsigned, cpu_ack;
	addr_t cpu_adr, mem_adr;
	size_t cpu_size;
	word_t cpu_dat_w, cpu_dat_r, mem_dat_w, mem_dat_r;
	logic mem_cyc, mem_stb, mem_we, mem_ack;

	logic [7:0] backing [SPAN]; // memory behind the cache
	logic [7:0] golden [SPAN]; // bytes as the cpu should see them
	logic ref_valid [`DC_SETS][2];
	logic ref_dirty [`DC_SETS][2];
	tag_t ref_tag [`DC_SETS][2];
	logic ref_lru [`DC_SETS];
	addr_t wr_adr_q [$];
	word_t wr_dat_q [$];
	addr_t rd_adr_q [$];
	int errors, proto_errors, cycles;
	int unsigned wait_left;

	dcache_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [7:0] fill_byte(int unsigned a);
		int unsigned h;
		h = a * 32'h9e3779b1;
		h = h ^ (h >> 15); // mix high bits down
		return h[7:0];
	endfunction

	function automatic word_t golden_word(span_t a);
		word_t v;
		v = '0;
		for (int b = 0; b < 8; b++) begin
			v = v | (word_t'(golden[a + span_t'(b)]) << (8 * b)); // little endian
		end
		return v;
	endfunction

	function automatic word_t expect_load(span_t a, size_t sz, logic uns);
		word_t v;
		int sh;
		sh = 64 - (8 << sz);
		v = golden_word(a) << sh; // addressed bytes to the top
		return uns ? (v >> sh) : word_t'($signed(v) >>> sh);
	endfunction

	task automatic serve_beat();
		span_t a;
		a = span_t'(mem_adr);
		if (mem_adr >= addr_t'(SPAN) || mem_adr[2:0] != 3'b000) begin
			$display("memory beat at %h is misaligned or outside the modelled range", mem_adr);
			proto_errors++;
		end else if (mem_we) begin
			wr_adr_q.push_back(mem_adr);
			wr_dat_q.push_back(mem_dat_w);
			for (int b = 0; b < 8; b++) begin
				backing[a + span_t'(b)] = 8'(mem_dat_w >> (8 * b));
			end
		end else begin
			rd_adr_q.push_back(mem_adr);
			mem_dat_r = '0;
			for (int b = 0; b < 8; b++) begin
				mem_dat_r = mem_dat_r | (word_t'(backing[a + span_t'(b)]) << (8 * b));
			end
		end
	endtask

	// memory slave, 0 to 3 wait states per beat
	initial begin
		mem_ack = 1'b0;
		mem_dat_r = '0;
		wait_left = 0;
		forever begin
			@(negedge clk);
			mem_ack = 1'b0;
			if (arst_n && mem_cyc && mem_stb) begin
				if (wait_left != 0) begin
					wait_left--;
				end else begin
					serve_beat();
					mem_ack = 1'b1;
					wait_left = $urandom_range(3, 0);
				end
			end
		end
	end

	task automatic run_access(logic we, addr_t adr, size_t sz, logic uns, word_t wd);
		index_t idx;
		tag_t t;
		logic hit0, hit1, pred_hit, way, vict_dirty;
		addr_t vict_base, line_base;
		word_t exp_data;
		idx = adr[OFF_W +: IDX_W];
		t = adr[`DC_ADDR_W-1 : OFF_W+IDX_W];
		hit0 = ref_valid[idx][0] && ref_tag[idx][0] == t;
		hit1 = ref_valid[idx][1] && ref_tag[idx][1] == t;
		pred_hit = hit0 || hit1;
		way = pred_hit ? hit1 : ref_lru[idx]; // victim on a miss
		vict_dirty = !pred_hit && ref_valid[idx][way] && ref_dirty[idx][way];
		vict_base = {ref_tag[idx][way], idx, {OFF_W{1'b0}}};
		line_base = {t, idx, {OFF_W{1'b0}}};
		wr_adr_q.delete();
		wr_dat_q.delete();
		rd_adr_q.delete();
		cpu_cyc = 1'b1;
		cpu_stb = 1'b1;
		cpu_we = we;
		cpu_adr = adr;
		cpu_size = sz;
		cpu_unsigned = uns;
		cpu_dat_w = wd;
		@(negedge clk);
		if (pred_hit && (!cpu_ack || mem_cyc)) begin
			$display("hit at %h was not answered one cycle after sampling", adr);
			proto_errors++;
		end
		if (!pred_hit && (cpu_ack || !mem_cyc)) begin
			$display("miss at %h did not start a memory burst", adr);
			proto_errors++;
		end
		while (!cpu_ack) begin
			@(negedge clk);
		end
		exp_data = expect_load(span_t'(adr), sz, uns);
		if (!we && cpu_dat_r !== exp_data) begin
			$display("Error: cpu_dat_r = %h, expected %h at %h", cpu_dat_r, exp_data, adr);
			errors++;
		end
		if (wr_adr_q.size() != (vict_dirty ? 8 : 0)) begin
			$display("access at %h wrote back %0d beats", adr, wr_adr_q.size());
			proto_errors++;
		end else begin
			for (int k = 0; k < wr_adr_q.size(); k++) begin
				if (wr_adr_q[k] !== vict_base + addr_t'(8 * k)) begin
					$display("Error: mem_adr = %h, expected %h", wr_adr_q[k],
						vict_base + addr_t'(8 * k));
					errors++;
				end
				if (wr_dat_q[k] !== golden_word(span_t'(wr_adr_q[k]))) begin
					$display("Error: mem_dat_w = %h, expected %h", wr_dat_q[k],
						golden_word(span_t'(wr_adr_q[k])));
					errors++;
				end
			end
		end
		if (rd_adr_q.size() != (pred_hit ? 0 : 8)) begin
			$display("access at %h refilled %0d beats", adr, rd_adr_q.size());
			proto_errors++;
		end else begin
			for (int k = 0; k < rd_adr_q.size(); k++) begin
				if (rd_adr_q[k] !== line_base + addr_t'(8 * k)) begin
					$display("Error: mem_adr = %h, expected %h", rd_adr_q[k],
						line_base + addr_t'(8 * k));
					errors++;
				end
			end
		end
		if (!pred_hit) begin
			ref_tag[idx][way] = t; // refill
			ref_valid[idx][way] = 1'b1;
			ref_dirty[idx][way] = 1'b0;
		end
		ref_lru[idx] = !way;
		if (we) begin
			ref_dirty[idx][way] = 1'b1;
			for (int b = 0; b < (1 << sz); b++) begin
				golden[span_t'(adr) + span_t'(b)] = 8'(wd >> (8 * b));
			end
		end
		@(negedge clk); // ack has dropped, state back in idle
	endtask

	initial begin
		cycles = 0;
		while (cycles < MAX_CYC) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the accesses did not complete", cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		addr_t adr, last_adr;
		size_t sz;
		void'($urandom(32'hdeee52dd));
		errors = 0;
		proto_errors = 0;
		arst_n = 1'b0;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		cpu_adr = '0;
		cpu_size = size_byte;
		cpu_unsigned = 1'b0;
		cpu_dat_w = '0;
		last_adr = '0;
		for (int a = 0; a < SPAN; a++) begin
			backing[span_t'(a)] = fill_byte(a);
			golden[span_t'(a)] = fill_byte(a);
		end
		ref_valid = '{default: '0};
		ref_dirty = '{default: '0};
		ref_tag = '{default: '0};
		ref_lru = '{default: '0};
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			if (cpu_ack || mem_cyc) begin
				$display("cache became active before the first request");
				proto_errors++;
			end
		end
		for (int i = 0; i < N_ACC; i++) begin
			r = $urandom;
			sz = size_t'(r[1:0]);
			// a quarter of the accesses reuse the last word
			adr = (r[3:2] == 2'b00) ? {last_adr[31:3], r[6:4]} : addr_t'(r[15:4]);
			adr = adr & ~((addr_t'(1) << sz) - addr_t'(1));
			run_access(r[16], adr, sz, r[17], {$urandom, $urandom});
			last_adr = adr;
			if (r[19:18] == 2'b00) begin
				cpu_cyc = 1'b0;
				cpu_stb = 1'b0;
				@(negedge clk);
			end
		end
		$display("%0d accesses: %0d data errors, %0d protocol errors", N_ACC, errors,
			proto_errors);
		if (errors == 0 && proto_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
